// ==== list.f ====
+incdir+.
mtx_pkg.sv
mod_adder.sv
mod_multiplier.sv
mtx_operand_store.sv
mtx_product.sv
mtx_top.sv
mtx_tb.sv

// ==== mod_adder.sv ====
// Modular adder and subtractor with registered result and ready pulse
`timescale 1ns/1ps
`default_nettype none

`include "mtx_params.svh"

module mod_adder (
  input  wire logic                CLK,
  input  wire logic                RST,
  input  wire logic                start,
  input  wire logic                subtract,
  input  wire mtx_pkg::mtx_elem_t  modulo,
  input  wire mtx_pkg::mtx_elem_t  a,
  input  wire mtx_pkg::mtx_elem_t  b,
  output logic                     ready,
  output mtx_pkg::mtx_elem_t       sum
);

  // One carry bit above the element width
  logic [`MTX_DATA_W:0] sum_raw;
  logic [`MTX_DATA_W:0] sum_wrap;
  logic [`MTX_DATA_W:0] diff_raw;
  logic [`MTX_DATA_W:0] diff_wrap;
  mtx_pkg::mtx_elem_t   result;

  assign sum_raw   = {1'b0, a} + {1'b0, b};
  assign sum_wrap  = sum_raw - {1'b0, modulo};
  // Top bit of diff_raw flags a borrow (a < b)
  assign diff_raw  = {1'b0, a} - {1'b0, b};
  assign diff_wrap = diff_raw + {1'b0, modulo};

  // Fold back into 0 .. modulo-1
  always_comb begin
    if (subtract) begin
      result = diff_raw[`MTX_DATA_W] ? diff_wrap[`MTX_DATA_W-1:0] : diff_raw[`MTX_DATA_W-1:0];
    end else begin
      result = (sum_raw >= {1'b0, modulo}) ? sum_wrap[`MTX_DATA_W-1:0]
                                           : sum_raw[`MTX_DATA_W-1:0];
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ready <= 1'b0;
    end else begin
      ready <= start;
    end
  end

  // Result held until the next start
  always_ff @(posedge CLK) begin
    if (start) begin
      sum <= result;
    end
  end

  // Single correction step only works for reduced operands
  a_operands_reduced : assert property (@(posedge CLK) disable iff (RST)
    start |-> (a < modulo) && (b < modulo));

endmodule

`default_nettype wire

// ==== mod_multiplier.sv ====
// Iterative shift-and-add modular multiplier, one bit of b per cycle
`timescale 1ns/1ps
`default_nettype none

`include "mtx_params.svh"

module mod_multiplier (
  input  wire logic                CLK,
  input  wire logic                RST,
  input  wire logic                start,
  input  wire mtx_pkg::mtx_elem_t  modulo,
  input  wire mtx_pkg::mtx_elem_t  a,
  input  wire mtx_pkg::mtx_elem_t  b,
  output logic                     ready,
  output mtx_pkg::mtx_elem_t       product
);

  localparam int STEP_W = $clog2(`MTX_DATA_W + 1);

  ////////////////////
  // Datapath
  ////////////////////

  mtx_pkg::mtx_elem_t   a_q;
  mtx_pkg::mtx_elem_t   b_q;
  mtx_pkg::mtx_elem_t   m_q;
  logic [`MTX_DATA_W:0] dbl;
  logic [`MTX_DATA_W:0] dbl_sub;
  mtx_pkg::mtx_elem_t   dbl_mod;
  logic [`MTX_DATA_W:0] add_raw;
  logic [`MTX_DATA_W:0] add_sub;
  mtx_pkg::mtx_elem_t   step_val;

  // 2*acc mod M
  assign dbl     = {product, 1'b0};
  assign dbl_sub = dbl - {1'b0, m_q};
  assign dbl_mod = (dbl >= {1'b0, m_q}) ? dbl_sub[`MTX_DATA_W-1:0] : dbl[`MTX_DATA_W-1:0];

  // Plus a mod M when the current bit of b is set
  assign add_raw  = {1'b0, dbl_mod} + {1'b0, a_q};
  assign add_sub  = add_raw - {1'b0, m_q};
  assign step_val = !b_q[`MTX_DATA_W-1] ? dbl_mod :
                    (add_raw >= {1'b0, m_q}) ? add_sub[`MTX_DATA_W-1:0]
                                             : add_raw[`MTX_DATA_W-1:0];

  ////////////////////
  // Control
  ////////////////////

  logic              busy;
  logic [STEP_W-1:0] steps;

  // 16 steps, ready rises with the last one
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy  <= 1'b0;
      steps <= '0;
      ready <= 1'b0;
    end else begin
      ready <= 1'b0;
      if (start) begin
        busy  <= 1'b1;
        steps <= STEP_W'(`MTX_DATA_W);
      end else if (busy) begin
        steps <= steps - 1'b1;
        if (steps == STEP_W'(1)) begin
          busy  <= 1'b0;
          ready <= 1'b1;
        end
      end
    end
  end

  // Operands latched on start, b shifted MSB first
  always_ff @(posedge CLK) begin
    if (start) begin
      a_q     <= a;
      b_q     <= b;
      m_q     <= modulo;
      product <= '0;
    end else if (busy) begin
      product <= step_val;
      b_q     <= b_q << 1;
    end
  end

  a_no_start_busy : assert property (@(posedge CLK) disable iff (RST)
    start |-> !busy);

endmodule

`default_nettype wire

// ==== mtx_operand_store.sv ====
// Operand buffers for A and B with strobed row and column write pointers
`timescale 1ns/1ps
`default_nettype none

`include "mtx_params.svh"

module mtx_operand_store (
  input  wire logic                CLK,
  input  wire logic                RST,
  input  wire logic                clear,
  input  wire mtx_pkg::mtx_load_t  load_a,
  input  wire mtx_pkg::mtx_load_t  load_b,
  input  wire mtx_pkg::mtx_idx_t   a_row,
  input  wire mtx_pkg::mtx_idx_t   a_col,
  input  wire mtx_pkg::mtx_idx_t   b_row,
  input  wire mtx_pkg::mtx_idx_t   b_col,
  output mtx_pkg::mtx_elem_t       a_elem,
  output mtx_pkg::mtx_elem_t       b_elem
);

  // Buffer 0 holds A, buffer 1 holds B
  mtx_pkg::mtx_load_t load [2];
  mtx_pkg::mtx_dim_t  row_q [2];
  mtx_pkg::mtx_dim_t  col_q [2];
  logic               fresh_q [2];
  mtx_pkg::mtx_dim_t  wr_row [2];
  mtx_pkg::mtx_dim_t  wr_col [2];
  mtx_pkg::mtx_elem_t mem [2][`MTX_MAX_DIM][`MTX_MAX_DIM];

  assign load[0] = load_a;
  assign load[1] = load_b;

  // Write address, row_start opens the next row at column 0
  always_comb begin
    for (int n = 0; n < 2; n++) begin
      if (load[n].row_start) begin
        wr_row[n] = fresh_q[n] ? '0 : row_q[n] + 1'b1;
        wr_col[n] = '0;
      end else begin
        wr_row[n] = row_q[n];
        wr_col[n] = col_q[n];
      end
    end
  end

  // Pointers restart on clear, loads in that cycle are dropped
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int n = 0; n < 2; n++) begin
        row_q[n]   <= '0;
        col_q[n]   <= '0;
        fresh_q[n] <= 1'b1;
      end
    end else if (clear) begin
      for (int n = 0; n < 2; n++) begin
        row_q[n]   <= '0;
        col_q[n]   <= '0;
        fresh_q[n] <= 1'b1;
      end
    end else begin
      for (int n = 0; n < 2; n++) begin
        if (load[n].elem) begin
          row_q[n]   <= wr_row[n];
          col_q[n]   <= wr_col[n] + 1'b1;
          fresh_q[n] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    for (int n = 0; n < 2; n++) begin
      if (load[n].elem && !clear) begin
        mem[n][wr_row[n][`MTX_IDX_W-1:0]][wr_col[n][`MTX_IDX_W-1:0]] <= load[n].data;
      end
    end
  end

  // Combinational read for the controller
  assign a_elem = mem[0][a_row][a_col];
  assign b_elem = mem[1][b_row][b_col];

  for (genvar g = 0; g < 2; g++) begin : g_chk
    a_ptr_in_range : assert property (@(posedge CLK) disable iff (RST)
      (load[g].elem && !clear) |-> (wr_row[g] < `MTX_MAX_DIM) && (wr_col[g] < `MTX_MAX_DIM));
  end

endmodule

`default_nettype wire

// ==== mtx_params.svh ====
// Element width, maximum matrix dimension and index widths for the matrix engine
`ifndef MTX_PARAMS_SVH
`define MTX_PARAMS_SVH

// Width of one element, of the modulus and of a partial sum
`define MTX_DATA_W 16

// Largest row or column count of any operand
`define MTX_MAX_DIM 4

// Row or column index, 0 to MTX_MAX_DIM-1
`define MTX_IDX_W 2

// Dimension value, one bit wider so that it can hold MTX_MAX_DIM
`define MTX_DIM_W 3

`endif

// ==== mtx_pkg.sv ====
// Element, index and dimension types, dims and load structs, controller state enum
`default_nettype none

`include "mtx_params.svh"

package mtx_pkg;

  // Scalar element, modulus or accumulator value
  typedef logic [`MTX_DATA_W-1:0] mtx_elem_t;
  typedef logic [`MTX_IDX_W-1:0]  mtx_idx_t;
  typedef logic [`MTX_DIM_W-1:0]  mtx_dim_t;

  // Shape of C = A x B, inner is both cols of A and rows of B
  typedef struct packed {
    mtx_dim_t rows_a;
    mtx_dim_t inner;
    mtx_dim_t cols_b;
  } mtx_dims_t;

  // One word of an operand load stream
  typedef struct packed {
    logic      row_start;
    logic      elem;
    mtx_elem_t data;
  } mtx_load_t;

  typedef enum logic [2:0] {
    STARTER, MULTIPLY, ACCUMULATE, EMIT, ENDER
  } mtx_state_t;

endpackage

`default_nettype wire

// ==== mtx_product.sv ====
// Matrix product controller FSM, multiply-accumulate loop and result stream
`timescale 1ns/1ps
`default_nettype none

`include "mtx_params.svh"

module mtx_product (
  input  wire logic                CLK,
  input  wire logic                RST,
  input  wire logic                START,
  input  wire mtx_pkg::mtx_dims_t  dims,
  input  wire mtx_pkg::mtx_elem_t  modulo,
  input  wire mtx_pkg::mtx_elem_t  a_elem,
  input  wire mtx_pkg::mtx_elem_t  b_elem,
  input  wire logic                mul_ready,
  input  wire mtx_pkg::mtx_elem_t  mul_product,
  input  wire logic                add_ready,
  input  wire mtx_pkg::mtx_elem_t  add_sum,
  output logic                     READY,
  output logic                     out_row_en,
  output logic                     out_elem_en,
  output mtx_pkg::mtx_elem_t       data_out,
  output logic                     mul_start,
  output logic                     add_start,
  output logic                     add_subtract,
  output mtx_pkg::mtx_elem_t       op_modulo,
  output mtx_pkg::mtx_elem_t       mul_a,
  output mtx_pkg::mtx_elem_t       mul_b,
  output mtx_pkg::mtx_elem_t       add_a,
  output mtx_pkg::mtx_elem_t       add_b,
  output mtx_pkg::mtx_idx_t        a_row,
  output mtx_pkg::mtx_idx_t        a_col,
  output mtx_pkg::mtx_idx_t        b_row,
  output mtx_pkg::mtx_idx_t        b_col
);

  mtx_pkg::mtx_state_t state;
  // i row of C, k column of C, j inner index
  mtx_pkg::mtx_idx_t   i;
  mtx_pkg::mtx_idx_t   j;
  mtx_pkg::mtx_idx_t   k;
  mtx_pkg::mtx_elem_t  acc;
  logic                last_i;
  logic                last_j;
  logic                last_k;

  assign last_i = (mtx_pkg::mtx_dim_t'(i) + 1'b1) == dims.rows_a;
  assign last_j = (mtx_pkg::mtx_dim_t'(j) + 1'b1) == dims.inner;
  assign last_k = (mtx_pkg::mtx_dim_t'(k) + 1'b1) == dims.cols_b;

  ////////////////////
  // Operand routing
  ////////////////////

  // A[i][j] times B[j][k]
  assign a_row = i;
  assign a_col = j;
  assign b_row = j;
  assign b_col = k;
  assign mul_a = a_elem;
  assign mul_b = b_elem;

  // Add starts in the product's ready cycle, saves a cycle per pair
  assign add_start = (state == mtx_pkg::MULTIPLY) && mul_ready;
  assign add_a     = acc;
  assign add_b     = mul_product;

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= mtx_pkg::STARTER;
      i            <= '0;
      j            <= '0;
      k            <= '0;
      acc          <= '0;
      mul_start    <= 1'b0;
      add_subtract <= 1'b0;
      out_elem_en  <= 1'b0;
      out_row_en   <= 1'b0;
      data_out     <= '0;
      READY        <= 1'b0;
    end else begin
      // Pulses by default
      mul_start   <= 1'b0;
      out_elem_en <= 1'b0;
      out_row_en  <= 1'b0;
      READY       <= 1'b0;
      case (state)
        mtx_pkg::STARTER: begin
          if (START) begin
            i            <= '0;
            j            <= '0;
            k            <= '0;
            acc          <= '0;
            // Product accumulates by addition only
            add_subtract <= 1'b0;
            mul_start    <= 1'b1;
            state        <= mtx_pkg::MULTIPLY;
          end
        end
        mtx_pkg::MULTIPLY: begin
          if (mul_ready) begin
            state <= mtx_pkg::ACCUMULATE;
          end
        end
        mtx_pkg::ACCUMULATE: begin
          if (add_ready) begin
            acc <= add_sum;
            if (last_j) begin
              j           <= '0;
              data_out    <= add_sum;
              out_elem_en <= 1'b1;
              out_row_en  <= (k == '0);
              state       <= mtx_pkg::EMIT;
            end else begin
              j         <= j + 1'b1;
              mul_start <= 1'b1;
              state     <= mtx_pkg::MULTIPLY;
            end
          end
        end
        mtx_pkg::EMIT: begin
          acc <= '0;
          if (last_k && last_i) begin
            k     <= '0;
            READY <= 1'b1;
            state <= mtx_pkg::ENDER;
          end else begin
            // Next column, or wrap to the next row
            k         <= last_k ? '0 : k + 1'b1;
            i         <= last_k ? i + 1'b1 : i;
            mul_start <= 1'b1;
            state     <= mtx_pkg::MULTIPLY;
          end
        end
        mtx_pkg::ENDER: begin
          state <= mtx_pkg::STARTER;
        end
        default: begin
          state <= mtx_pkg::STARTER;
        end
      endcase
    end
  end

  // Modulus captured once per product
  always_ff @(posedge CLK) begin
    if (state == mtx_pkg::STARTER && START) begin
      op_modulo <= modulo;
    end
  end

  a_dims_legal : assert property (@(posedge CLK) disable iff (RST)
    (START && state == mtx_pkg::STARTER) |->
      (dims.rows_a >= 1) && (dims.rows_a <= `MTX_MAX_DIM) &&
      (dims.inner  >= 1) && (dims.inner  <= `MTX_MAX_DIM) &&
      (dims.cols_b >= 1) && (dims.cols_b <= `MTX_MAX_DIM));

endmodule

`default_nettype wire

// ==== mtx_tb.sv ====
// Testbench for the matrix product engine with random stimulus and a reference model
`timescale 1ns/1ps
`default_nettype none

`include "mtx_params.svh"

module mtx_tb;

  // Worst case 40 products of 4x4x4 at 19 cycles per pair, plus load time
  localparam int TIMEOUT_CYCLES = 40 * (4 * 4 * 4 * 19 + 40) + 10000;

  logic                CLK;
  logic                RST;
  logic                START;
  mtx_pkg::mtx_dims_t  dims;
  mtx_pkg::mtx_elem_t  modulo;
  mtx_pkg::mtx_load_t  load_a;
  mtx_pkg::mtx_load_t  load_b;
  logic                READY;
  logic                out_row_en;
  logic                out_elem_en;
  mtx_pkg::mtx_elem_t  data_out;

  // Model operands and expected stream
  int          ma [`MTX_MAX_DIM][`MTX_MAX_DIM];
  int          mb [`MTX_MAX_DIM][`MTX_MAX_DIM];
  int          exp_q [$];
  int          exp_row_q [$];
  string       test_name;
  int          errors;
  int          elem_count;
  int          row_count;
  int          ready_count;
  int          cycle_count;
  int          exp_val;
  int          exp_row;
  logic        elem_prev;
  logic [31:0] rng;

  mtx_top DUT (
    .CLK(CLK), .RST(RST), .START(START), .dims(dims), .modulo(modulo),
    .load_a(load_a), .load_b(load_b), .READY(READY), .out_row_en(out_row_en),
    .out_elem_en(out_elem_en), .data_out(data_out)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Uniform-ish value in 0 .. n-1
  function automatic int rand_below(input int n);
    rng = xorshift(rng);
    return int'(rng % 32'(n));
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected !== actual) begin
      errors++;
      $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic fill_random(input int ra, input int inn, input int cb, input int m);
    for (int r = 0; r < ra; r++) begin
      for (int c = 0; c < inn; c++) begin
        ma[r][c] = rand_below(m);
      end
    end
    for (int r = 0; r < inn; r++) begin
      for (int c = 0; c < cb; c++) begin
        mb[r][c] = rand_below(m);
      end
    end
  endtask

  // Row-major, row_start on column 0, A then B
  task automatic load_matrices(input int ra, input int inn, input int cb);
    for (int r = 0; r < ra; r++) begin
      for (int c = 0; c < inn; c++) begin
        @(negedge CLK);
        load_a.row_start = (c == 0);
        load_a.elem      = 1'b1;
        load_a.data      = 16'(ma[r][c]);
      end
    end
    @(negedge CLK);
    load_a = '0;
    for (int r = 0; r < inn; r++) begin
      for (int c = 0; c < cb; c++) begin
        load_b.row_start = (c == 0);
        load_b.elem      = 1'b1;
        load_b.data      = 16'(mb[r][c]);
        @(negedge CLK);
      end
    end
    load_b = '0;
  endtask

  // Load, queue the model results, start, wait for READY, then count pulses
  task automatic run_product(input string name, input int ra, input int inn, input int cb,
                             input int m, input bit poke_start);
    int     elems_before;
    int     rows_before;
    int     ready_before;
    longint acc;
    test_name = name;
    load_matrices(ra, inn, cb);
    for (int i = 0; i < ra; i++) begin
      for (int k = 0; k < cb; k++) begin
        acc = 0;
        for (int j = 0; j < inn; j++) begin
          acc = (acc + (longint'(ma[i][j]) * longint'(mb[j][k])) % m) % m;
        end
        exp_q.push_back(int'(acc));
        exp_row_q.push_back(int'(k == 0));
      end
    end
    elems_before = elem_count;
    rows_before  = row_count;
    ready_before = ready_count;
    @(negedge CLK);
    dims.rows_a = 3'(ra);
    dims.inner  = 3'(inn);
    dims.cols_b = 3'(cb);
    modulo      = 16'(m);
    START       = 1'b1;
    @(negedge CLK);
    START = 1'b0;
    // Second START lands while the first result is out
    if (poke_start) begin
      while (!out_elem_en) begin
        @(negedge CLK);
      end
      START = 1'b1;
      @(negedge CLK);
      START = 1'b0;
    end
    while (!READY) begin
      @(negedge CLK);
    end
    repeat (3) @(negedge CLK);
    check_value({name, " elements"}, ra * cb, elem_count - elems_before);
    check_value({name, " row pulses"}, ra, row_count - rows_before);
    check_value({name, " READY pulses"}, 1, ready_count - ready_before);
  endtask

  ////////////////////
  // Output monitor
  ////////////////////

  // Outputs change on posedge, so negedge sees them settled
  always @(negedge CLK) begin
    if (!RST) begin
      if (out_elem_en) begin
        elem_count++;
        if (out_row_en) begin
          row_count++;
        end
        if (exp_q.size() == 0) begin
          errors++;
          $display("ERROR: %s got a result element when none was expected", test_name);
        end else begin
          exp_val = exp_q.pop_front();
          exp_row = exp_row_q.pop_front();
          check_value({test_name, " data_out"}, exp_val, int'(data_out));
          check_value({test_name, " out_row_en"}, exp_row, int'(out_row_en));
        end
      end else if (out_row_en) begin
        errors++;
        $display("ERROR: %s saw a row marker without an element", test_name);
      end
      if (READY) begin
        ready_count++;
        if (exp_q.size() != 0) begin
          errors++;
          $display("ERROR: %s READY came with %0d elements still missing",
                   test_name, exp_q.size());
        end
        if (!elem_prev) begin
          errors++;
          $display("ERROR: %s READY did not come one cycle after the last element",
                   test_name);
        end
      end
      elem_prev = out_elem_en;
    end
  end

  // Run limit
  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("ERROR: timeout after %0d cycles in %s", cycle_count, test_name);
      $display("sim failed");
      $finish;
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    int ra;
    int inn;
    int cb;
    int m;
    rng         = 32'h08d037b5;
    errors      = 0;
    elem_count  = 0;
    row_count   = 0;
    ready_count = 0;
    cycle_count = 0;
    elem_prev   = 1'b0;
    test_name   = "reset";
    RST         = 1'b1;
    START       = 1'b0;
    dims        = '0;
    modulo      = '0;
    load_a      = '0;
    load_b      = '0;
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    // Outputs idle until the first START
    test_name = "reset_quiet";
    repeat (8) begin
      @(negedge CLK);
      check_value("reset_quiet strobes", 0, int'({READY, out_row_en, out_elem_en}));
      check_value("reset_quiet data_out", 0, int'(data_out));
    end

    // Fixed 2x2 by 2x2, mod 97
    ma[0][0] = 3;
    ma[0][1] = 5;
    ma[1][0] = 7;
    ma[1][1] = 11;
    mb[0][0] = 13;
    mb[0][1] = 17;
    mb[1][0] = 19;
    mb[1][1] = 23;
    run_product("small_exact", 2, 2, 2, 97, 1'b0);

    for (int t = 0; t < 30; t++) begin
      ra  = 1 + rand_below(4);
      inn = 1 + rand_below(4);
      cb  = 1 + rand_below(4);
      m   = 2 + rand_below(65534);
      fill_random(ra, inn, cb, m);
      run_product($sformatf("random_%0d", t), ra, inn, cb, m, 1'b0);
    end

    // Operands just below the largest 16-bit prime
    for (int p = 0; p < 2; p++) begin
      m = 65521;
      for (int r = 0; r < 4; r++) begin
        for (int c = 0; c < 4; c++) begin
          ma[r][c] = m - 1 - rand_below(8);
          mb[r][c] = m - 1 - rand_below(8);
        end
      end
      run_product($sformatf("wraparound_%0d", p), 4 - p, 4, 4 - 2 * p, m, 1'b0);
    end

    // Busy START ignored, then same shape with new operands
    ra  = 1 + rand_below(4);
    inn = 1 + rand_below(4);
    cb  = 1 + rand_below(4);
    m   = 2 + rand_below(65534);
    fill_random(ra, inn, cb, m);
    run_product("busy_start", ra, inn, cb, m, 1'b1);
    fill_random(ra, inn, cb, m);
    run_product("reload", ra, inn, cb, m, 1'b0);

    $display("errors: %0d, elements: %0d, cycles: %0d", errors, elem_count, cycle_count);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mtx_top.sv ====
// Matrix product engine top level, store, controller, multiplier and adder
`timescale 1ns/1ps
`default_nettype none

module mtx_top (
  input  wire logic                CLK,
  input  wire logic                RST,
  input  wire logic                START,
  input  wire mtx_pkg::mtx_dims_t  dims,
  input  wire mtx_pkg::mtx_elem_t  modulo,
  input  wire mtx_pkg::mtx_load_t  load_a,
  input  wire mtx_pkg::mtx_load_t  load_b,
  output logic                     READY,
  output logic                     out_row_en,
  output logic                     out_elem_en,
  output mtx_pkg::mtx_elem_t       data_out
);

  // Store read port
  mtx_pkg::mtx_idx_t  a_row, a_col, b_row, b_col;
  mtx_pkg::mtx_elem_t a_elem, b_elem;

  // Scalar multiplier and adder
  logic               mul_start, mul_ready, add_start, add_ready, add_subtract;
  mtx_pkg::mtx_elem_t op_modulo, mul_a, mul_b, mul_product, add_a, add_b, add_sum;

  mtx_operand_store u_store (
    .CLK(CLK), .RST(RST), .clear(START), .load_a(load_a), .load_b(load_b),
    .a_row(a_row), .a_col(a_col), .b_row(b_row), .b_col(b_col),
    .a_elem(a_elem), .b_elem(b_elem)
  );

  mtx_product u_product (
    .CLK(CLK), .RST(RST), .START(START), .dims(dims), .modulo(modulo),
    .a_elem(a_elem), .b_elem(b_elem),
    .mul_ready(mul_ready), .mul_product(mul_product),
    .add_ready(add_ready), .add_sum(add_sum),
    .READY(READY), .out_row_en(out_row_en), .out_elem_en(out_elem_en), .data_out(data_out),
    .mul_start(mul_start), .add_start(add_start), .add_subtract(add_subtract),
    .op_modulo(op_modulo), .mul_a(mul_a), .mul_b(mul_b), .add_a(add_a), .add_b(add_b),
    .a_row(a_row), .a_col(a_col), .b_row(b_row), .b_col(b_col)
  );

  mod_multiplier u_mul (
    .CLK(CLK), .RST(RST), .start(mul_start), .modulo(op_modulo),
    .a(mul_a), .b(mul_b), .ready(mul_ready), .product(mul_product)
  );

  mod_adder u_add (
    .CLK(CLK), .RST(RST), .start(add_start), .subtract(add_subtract), .modulo(op_modulo),
    .a(add_a), .b(add_b), .ready(add_ready), .sum(add_sum)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log && \
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module mtx_tb -o mtx_sim && \
./obj_dir/mtx_sim > sim.log 2>&1
grep -q "^sim passed$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
